// File: Bender.yml
package:
  name: alu_ops_config_loader

sources:
  - logic/alu_cfg_pkg.sv
  - logic/program_word_filter.sv
  - logic/alu_cfg_assembler.sv
  - logic/alu_cfg_fifo.sv
  - logic/alu_ops_config_loader.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/alu_ops_config_loader_asserts.sv
      - test/alu_ops_config_loader_tb.sv

// File: logic/alu_cfg_assembler.sv
// ALU configuration assembler
// counts a run of program words and captures the configuration fields
// by their position in the run, then pushes the finished record

module alu_cfg_assembler (
    input  logic                           ap_clk,
    input  logic                           areset_alu_ops_generator,
    input  logic                           word_valid,
    input  logic                           word_is_start,
    input  logic [alu_cfg_pkg::DATA_W-1:0] word_data,
    output logic                           cfg_push,
    output alu_cfg_pkg::alu_cfg_t          cfg_push_data
);

localparam int POS_W = $clog2(alu_cfg_pkg::SEQ_LEN);
localparam logic [POS_W-1:0] LAST_POS = POS_W'(alu_cfg_pkg::SEQ_LEN - 1);

// bit slices of the field words
localparam int OP_W      = $bits(alu_cfg_pkg::alu_op_t);
localparam int MOD_LO    = alu_cfg_pkg::NUM_FIELDS;
localparam int MOD_HI    = MOD_LO + alu_cfg_pkg::ID_W - 1;
localparam int ENG_LO    = MOD_HI + 1;
localparam int ENG_HI    = ENG_LO + alu_cfg_pkg::ID_W - 1;

logic             run_active;
logic [POS_W-1:0] run_pos;
logic             take_word;
logic [POS_W-1:0] word_pos;
logic             last_word;

// ----------------------------------------
// run tracking
// ----------------------------------------
// idle only opens on the start index, an open run takes every word
assign take_word = word_valid & (run_active | word_is_start);
assign word_pos  = run_active ? run_pos : '0;
assign last_word = (word_pos == LAST_POS);

always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        run_active <= 1'b0;
        run_pos    <= '0;
        cfg_push   <= 1'b0;
    end else begin
        cfg_push <= 1'b0;
        if (take_word) begin
            if (last_word) begin
                run_active <= 1'b0;
                run_pos    <= '0;
                cfg_push   <= 1'b1;
            end else begin
                run_active <= 1'b1;
                run_pos    <= word_pos + 1'b1;
            end
        end
    end
end

// ----------------------------------------
// field capture
// ----------------------------------------
// words 5 and up are padding
always_ff @(posedge ap_clk) begin
    if (take_word) begin
        case (word_pos)
            POS_W'(0): begin
                cfg_push_data.operation <= alu_cfg_pkg::alu_op_t'(word_data[OP_W-1:0]);
            end
            POS_W'(1): begin
                cfg_push_data.alu_mask    <= word_data[alu_cfg_pkg::NUM_FIELDS-1:0];
                cfg_push_data.dest_module <= word_data[MOD_HI:MOD_LO];
                cfg_push_data.dest_engine <= word_data[ENG_HI:ENG_LO];
            end
            POS_W'(2): begin
                cfg_push_data.const_mask <= word_data[alu_cfg_pkg::NUM_FIELDS-1:0];
            end
            POS_W'(3): begin
                cfg_push_data.const_value <= word_data;
            end
            POS_W'(4): begin
                cfg_push_data.ops_mask <= word_data[alu_cfg_pkg::OPS_MASK_W-1:0];
            end
            default: ;
        endcase
    end
end

endmodule : alu_cfg_assembler

// File: logic/alu_cfg_fifo.sv
// configuration FIFO
// circular buffer of finished configurations with a registered read port,
// a read strobe returns the oldest entry one cycle later

module alu_cfg_fifo (
    input  logic                  ap_clk,
    input  logic                  areset_alu_ops_generator,
    input  logic                  push,
    input  alu_cfg_pkg::alu_cfg_t push_data,
    input  logic                  rd_en,
    output logic                  pop_valid,
    output alu_cfg_pkg::alu_cfg_t pop_data,
    output logic                  empty,
    output logic                  full
);

localparam int PTR_W = $clog2(alu_cfg_pkg::CFG_FIFO_DEPTH);

alu_cfg_pkg::alu_cfg_t mem [alu_cfg_pkg::CFG_FIFO_DEPTH];

// pointers carry one wrap bit above the address
logic [PTR_W:0] wr_ptr;
logic [PTR_W:0] rd_ptr;
logic           do_push;
logic           do_pop;

// ----------------------------------------
// status
// ----------------------------------------
assign empty = (wr_ptr == rd_ptr);
assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
               (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

// push while full is lost, read while empty is ignored
assign do_push = push & ~full;
assign do_pop  = rd_en & ~empty;

// ----------------------------------------
// pointers and read strobe
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        wr_ptr    <= '0;
        rd_ptr    <= '0;
        pop_valid <= 1'b0;
    end else begin
        pop_valid <= do_pop;
        if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end
end

// ----------------------------------------
// storage
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    if (do_push) begin
        mem[wr_ptr[PTR_W-1:0]] <= push_data;
    end
end

// data held until the next pop
always_ff @(posedge ap_clk) begin
    if (do_pop) begin
        pop_data <= mem[rd_ptr[PTR_W-1:0]];
    end
end

endmodule : alu_cfg_fifo

// File: logic/alu_cfg_pkg.sv
// ALU configuration loader definitions
// widths, response commands, ALU operations and the configuration record

package alu_cfg_pkg;

// ----------------------------------------
// widths
// ----------------------------------------
localparam int DATA_W     = 32;
localparam int INDEX_W    = 8;
localparam int NUM_FIELDS = 4;
localparam int OPS_MASK_W = NUM_FIELDS * NUM_FIELDS;
localparam int ID_W       = 4;

// ----------------------------------------
// program window and buffering
// ----------------------------------------
// words per program run with the fields in the first five
localparam int SEQ_LEN        = 16;
localparam int CFG_FIFO_DEPTH = 16;

// response command codes
typedef enum logic [1:0] {
    CMD_INVALID,
    CMD_MEM_READ,
    CMD_MEM_WRITE,
    CMD_MEM_PROGRAM
} cmd_t;

// ALU operations understood by the engine
typedef enum logic [3:0] {
    NOP,
    ADD,
    SUB,
    MUL,
    ACC,
    DIV,
    GREATER,
    LESS,
    EQUAL,
    PASS
} alu_op_t;

// one finished configuration
typedef struct packed {
    alu_op_t                 operation;
    logic [NUM_FIELDS-1:0]   alu_mask;
    logic [NUM_FIELDS-1:0]   const_mask;
    logic [DATA_W-1:0]       const_value;
    logic [OPS_MASK_W-1:0]   ops_mask;
    logic [ID_W-1:0]         dest_module;
    logic [ID_W-1:0]         dest_engine;
} alu_cfg_t;

endpackage : alu_cfg_pkg

// File: logic/alu_ops_config_loader.sv
// ALU operation configuration loader
// filters program words from the memory response stream, assembles one
// configuration per run and buffers it for the consumer

module alu_ops_config_loader #(
    parameter int seq_base = 0
) (
    input  logic                            ap_clk,
    input  logic                            areset_alu_ops_generator,
    // memory response stream
    input  logic                            resp_valid,
    input  alu_cfg_pkg::cmd_t               resp_cmd,
    input  logic [alu_cfg_pkg::INDEX_W-1:0] resp_index,
    input  logic [alu_cfg_pkg::DATA_W-1:0]  resp_data,
    // configuration output
    input  logic                            cfg_rd_en,
    output logic                            cfg_valid,
    output alu_cfg_pkg::alu_cfg_t           cfg,
    output logic                            cfg_empty,
    output logic                            cfg_full
);

logic                           word_valid;
logic                           word_is_start;
logic [alu_cfg_pkg::DATA_W-1:0] word_data;
logic                           cfg_push;
alu_cfg_pkg::alu_cfg_t          cfg_push_data;

// ----------------------------------------
// input filter
// ----------------------------------------
program_word_filter #(
    .seq_base(seq_base)
) i_program_word_filter (
    .ap_clk                  (ap_clk),
    .areset_alu_ops_generator(areset_alu_ops_generator),
    .resp_valid              (resp_valid),
    .resp_cmd                (resp_cmd),
    .resp_index              (resp_index),
    .resp_data               (resp_data),
    .word_valid              (word_valid),
    .word_is_start           (word_is_start),
    .word_data               (word_data)
);

// ----------------------------------------
// run assembly
// ----------------------------------------
alu_cfg_assembler i_alu_cfg_assembler (
    .ap_clk                  (ap_clk),
    .areset_alu_ops_generator(areset_alu_ops_generator),
    .word_valid              (word_valid),
    .word_is_start           (word_is_start),
    .word_data               (word_data),
    .cfg_push                (cfg_push),
    .cfg_push_data           (cfg_push_data)
);

// ----------------------------------------
// output buffer
// ----------------------------------------
alu_cfg_fifo i_alu_cfg_fifo (
    .ap_clk                  (ap_clk),
    .areset_alu_ops_generator(areset_alu_ops_generator),
    .push                    (cfg_push),
    .push_data               (cfg_push_data),
    .rd_en                   (cfg_rd_en),
    .pop_valid               (cfg_valid),
    .pop_data                (cfg),
    .empty                   (cfg_empty),
    .full                    (cfg_full)
);

endmodule : alu_ops_config_loader

// File: logic/program_word_filter.sv
// program word filter
// registers the response stream and passes only memory program words
// whose sequence index falls inside this engine's window

module program_word_filter #(
    parameter int seq_base = 0
) (
    input  logic                            ap_clk,
    input  logic                            areset_alu_ops_generator,
    input  logic                            resp_valid,
    input  alu_cfg_pkg::cmd_t               resp_cmd,
    input  logic [alu_cfg_pkg::INDEX_W-1:0] resp_index,
    input  logic [alu_cfg_pkg::DATA_W-1:0]  resp_data,
    output logic                            word_valid,
    output logic                            word_is_start,
    output logic [alu_cfg_pkg::DATA_W-1:0]  word_data
);

// window bounds one bit wider so the top index cannot wrap
localparam logic [alu_cfg_pkg::INDEX_W:0] INDEX_MIN =
    (alu_cfg_pkg::INDEX_W + 1)'(seq_base);
localparam logic [alu_cfg_pkg::INDEX_W:0] INDEX_MAX =
    (alu_cfg_pkg::INDEX_W + 1)'(seq_base + alu_cfg_pkg::SEQ_LEN - 1);

logic                            resp_valid_reg;
alu_cfg_pkg::cmd_t               resp_cmd_reg;
logic [alu_cfg_pkg::INDEX_W-1:0] resp_index_reg;
logic [alu_cfg_pkg::INDEX_W:0]   index_ext;
logic                            is_program;
logic                            in_window;

// ----------------------------------------
// input registers
// ----------------------------------------
always_ff @(posedge ap_clk) begin
    if (areset_alu_ops_generator) begin
        resp_valid_reg <= 1'b0;
    end else begin
        resp_valid_reg <= resp_valid;
    end
end

always_ff @(posedge ap_clk) begin
    resp_cmd_reg   <= resp_cmd;
    resp_index_reg <= resp_index;
    word_data      <= resp_data;
end

// ----------------------------------------
// command and window check
// ----------------------------------------
assign index_ext     = {1'b0, resp_index_reg};
assign is_program    = (resp_cmd_reg == alu_cfg_pkg::CMD_MEM_PROGRAM);
assign in_window     = (index_ext >= INDEX_MIN) && (index_ext <= INDEX_MAX);
assign word_valid    = resp_valid_reg & is_program & in_window;
assign word_is_start = (index_ext == INDEX_MIN);

endmodule : program_word_filter

// File: project.f
logic/alu_cfg_pkg.sv
logic/program_word_filter.sv
logic/alu_cfg_assembler.sv
logic/alu_cfg_fifo.sv
logic/alu_ops_config_loader.sv
test/tb_clock_gen.sv
test/alu_ops_config_loader_asserts.sv
test/alu_ops_config_loader_tb.sv

// File: test/alu_ops_config_loader_asserts.sv
// configuration FIFO protocol checks
// read strobe timing and status flag consistency

module alu_ops_config_loader_asserts (
    input logic ap_clk,
    input logic areset_alu_ops_generator,
    input logic rd_en,
    input logic pop_valid,
    input logic empty,
    input logic full
);

timeunit 1ns;
timeprecision 100ps;

// number of failed assertions so far
int fail_count = 0;

no_pop_from_empty : assert property (
    @(posedge ap_clk) disable iff (areset_alu_ops_generator) rd_en && empty |=> !pop_valid
) else begin
    fail_count++;
    $error("pop_valid after a read on an empty FIFO");
end

flags_exclusive : assert property (
    @(posedge ap_clk) disable iff (areset_alu_ops_generator) !(empty && full)
) else begin
    fail_count++;
    $error("empty and full high together");
end

// one strobe per pop
pop_single_cycle : assert property (
    @(posedge ap_clk) disable iff (areset_alu_ops_generator) pop_valid |=> !pop_valid
) else begin
    fail_count++;
    $error("pop_valid held longer than one cycle");
end

endmodule : alu_ops_config_loader_asserts

bind alu_cfg_fifo alu_ops_config_loader_asserts i_fifo_asserts (.*);

// File: test/alu_ops_config_loader_tb.sv
// testbench for the ALU operation configuration loader
// applies a table of program runs and checks every popped
// configuration against a queue of expected records

module alu_ops_config_loader_tb;

timeunit 1ns;
timeprecision 100ps;

localparam int CLK_PERIOD     = 8;
localparam int SEQ_BASE       = 32;
localparam int SEQ_LEN        = alu_cfg_pkg::SEQ_LEN;
localparam int DEPTH          = alu_cfg_pkg::CFG_FIFO_DEPTH;
localparam int INDEX_W        = alu_cfg_pkg::INDEX_W;
localparam int DATA_W         = alu_cfg_pkg::DATA_W;
// last word to FIFO flags through filter, assembler and FIFO
localparam int SETTLE_CYCLES  = 3;
localparam int POP_WAIT_LIMIT = 8;
localparam int CYCLES_PER_RUN = 2 * SEQ_LEN + SETTLE_CYCLES + 8;
localparam int MARGIN_CYCLES  = 100;

typedef struct packed {
    logic [7:0] start_offset;
    logic [7:0] word_count;
    logic [7:0] repeats;
    logic [7:0] reset_after;
    logic       foreign;
    logic       pop;
} run_entry_t;

localparam int NUM_ENTRIES = 8;
// offset from base, words, repeats, reset after word, foreign, pop
localparam run_entry_t RUN_TABLE [NUM_ENTRIES] = '{
    '{8'd0, 8'd16, 8'd1, 8'd0, 1'b0, 1'b1},
    '{8'd0, 8'd16, 8'd1, 8'd0, 1'b1, 1'b1},
    '{8'd1, 8'd15, 8'd1, 8'd0, 1'b0, 1'b1},   // never hits the start index
    '{8'd0, 8'd16, 8'd3, 8'd0, 1'b0, 1'b1},
    '{8'd0, 8'd16, 8'd17, 8'd0, 1'b0, 1'b1},  // one more than the FIFO holds
    '{8'd0, 8'd16, 8'd1, 8'd0, 1'b0, 1'b0},   // left in the FIFO across the reset
    '{8'd0, 8'd16, 8'd1, 8'd7, 1'b0, 1'b0},
    '{8'd0, 8'd16, 8'd1, 8'd0, 1'b0, 1'b1}
};

logic                  ap_clk;
logic                  por_reset;
logic                  tb_reset;
logic                  areset_alu_ops_generator;
logic                  resp_valid;
alu_cfg_pkg::cmd_t     resp_cmd;
logic [INDEX_W-1:0]    resp_index;
logic [DATA_W-1:0]     resp_data;
logic                  cfg_rd_en;
logic                  cfg_valid;
alu_cfg_pkg::alu_cfg_t cfg;
logic                  cfg_empty;
logic                  cfg_full;

integer                seed = 32'h3926_ec06;
int                    check_count = 0;
int                    error_count = 0;
alu_cfg_pkg::alu_cfg_t exp_q [$];

assign areset_alu_ops_generator = por_reset | tb_reset;

tb_clock_gen #(.period_ns(CLK_PERIOD), .reset_cycles(3)) i_tb_clock_gen (
    .ap_clk   (ap_clk),
    .por_reset(por_reset)
);

alu_ops_config_loader #(.seq_base(SEQ_BASE)) i_alu_ops_config_loader (.*);

// ----------------------------------------
// model and checks
// ----------------------------------------
function automatic alu_cfg_pkg::alu_cfg_t build_cfg(input logic [DATA_W-1:0] words [SEQ_LEN]);
    alu_cfg_pkg::alu_cfg_t rec;
    rec.operation   = alu_cfg_pkg::alu_op_t'(words[0][3:0]);
    rec.alu_mask    = words[1][3:0];
    rec.dest_module = words[1][7:4];
    rec.dest_engine = words[1][11:8];
    rec.const_mask  = words[2][3:0];
    rec.const_value = words[3];
    rec.ops_mask    = words[4][15:0];
    return rec;
endfunction

task automatic check_bit(input logic got, input logic want, input string what);
    check_count++;
    if (got !== want) begin
        error_count++;
        $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
    end
endtask

task automatic check_reset_outputs();
    check_bit(cfg_valid, 1'b0, "cfg_valid in reset");
    check_bit(cfg_empty, 1'b1, "cfg_empty in reset");
    check_bit(cfg_full, 1'b0, "cfg_full in reset");
endtask

// ----------------------------------------
// stimulus
// ----------------------------------------
task automatic drive_word(input alu_cfg_pkg::cmd_t cmd, input int index, input logic [31:0] data);
    @(negedge ap_clk);
    resp_valid = 1'b1;
    resp_cmd   = cmd;
    resp_index = INDEX_W'(index);
    resp_data  = data;
endtask

task automatic apply_reset();
    @(negedge ap_clk);
    resp_valid = 1'b0;
    tb_reset   = 1'b1;
    repeat (2) @(negedge ap_clk);
    check_reset_outputs();
    tb_reset = 1'b0;
    exp_q.delete();
endtask

task automatic send_run(input run_entry_t entry);
    logic [DATA_W-1:0] words [SEQ_LEN];
    int k;
    for (k = 0; k < int'(entry.word_count); k++) begin
        if (entry.reset_after != 0 && k == int'(entry.reset_after)) begin
            apply_reset();
            return;
        end
        // wrong command in the window, or program word past its end
        if (entry.foreign && (k % 2 == 0)) begin
            drive_word(alu_cfg_pkg::CMD_MEM_WRITE, SEQ_BASE + k, $random(seed));
        end else if (entry.foreign) begin
            drive_word(alu_cfg_pkg::CMD_MEM_PROGRAM, SEQ_BASE + SEQ_LEN + k, $random(seed));
        end
        words[k] = (k == 0) ? ($unsigned($random(seed)) % 10) : $random(seed);
        drive_word(alu_cfg_pkg::CMD_MEM_PROGRAM, SEQ_BASE + entry.start_offset + k, words[k]);
    end
    @(negedge ap_clk);
    resp_valid = 1'b0;
    repeat (SETTLE_CYCLES - 1) @(negedge ap_clk);
    // a full FIFO drops the run
    if (entry.start_offset == 0 && entry.word_count == SEQ_LEN && exp_q.size() < DEPTH) begin
        exp_q.push_back(build_cfg(words));
    end
    check_bit(cfg_empty, exp_q.size() == 0, "cfg_empty after run");
    check_bit(cfg_full, exp_q.size() == DEPTH, "cfg_full after run");
endtask

task automatic pop_one(input logic want_data, input alu_cfg_pkg::alu_cfg_t expected);
    @(negedge ap_clk);
    cfg_rd_en = 1'b1;
    @(negedge ap_clk);
    cfg_rd_en = 1'b0;
    check_bit(cfg_valid, want_data, "cfg_valid one cycle after cfg_rd_en");
    if (want_data) begin
        check_count++;
        if (cfg !== expected) begin
            error_count++;
            $display("[ERROR] %0t: configuration %h, expected %h", $time, cfg, expected);
        end
    end
    @(negedge ap_clk);
    check_bit(cfg_valid, 1'b0, "cfg_valid after its strobe");
endtask

task automatic drain_and_check();
    alu_cfg_pkg::alu_cfg_t expected;
    int waited;
    while (exp_q.size() > 0) begin
        expected = exp_q.pop_front();
        waited   = 0;
        while (cfg_empty && waited < POP_WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (cfg_empty) begin
            error_count++;
            $display("cfg_empty never fell although a configuration was expected");
        end
        pop_one(1'b1, expected);
    end
    // extra pop on the empty FIFO
    pop_one(1'b0, '0);
endtask

// ----------------------------------------
// test sequence
// ----------------------------------------
initial begin : stimulus
    int e;
    int r;
    int assert_failures;
    tb_reset   = 1'b0;
    resp_valid = 1'b0;
    resp_cmd   = alu_cfg_pkg::CMD_INVALID;
    resp_index = '0;
    resp_data  = '0;
    cfg_rd_en  = 1'b0;
    @(negedge ap_clk);
    while (por_reset) begin
        @(negedge ap_clk);
    end
    check_reset_outputs();
    for (e = 0; e < NUM_ENTRIES; e++) begin
        for (r = 0; r < int'(RUN_TABLE[e].repeats); r++) begin
            send_run(RUN_TABLE[e]);
        end
        if (RUN_TABLE[e].pop) begin
            drain_and_check();
        end
    end
    assert_failures = i_alu_ops_config_loader.i_alu_cfg_fifo.i_fifo_asserts.fail_count;
    $display("%0d checks, %0d errors, %0d assertion failures",
             check_count, error_count, assert_failures);
    if (error_count == 0 && assert_failures == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

initial begin : watchdog
    int limit_cycles;
    int e;
    limit_cycles = MARGIN_CYCLES;
    for (e = 0; e < NUM_ENTRIES; e++) begin
        limit_cycles += RUN_TABLE[e].repeats * CYCLES_PER_RUN;
    end
    #(limit_cycles * CLK_PERIOD);
    $display("timeout: the test sequence did not finish within %0d cycles", limit_cycles);
    $display("tests failed");
    $finish;
end

endmodule : alu_ops_config_loader_tb

// File: test/tb_clock_gen.sv
// testbench clock and power-on reset source
// free running clock, reset held for a fixed number of rising edges

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 3
) (
    output logic ap_clk,
    output logic por_reset
);

timeunit 1ns;
timeprecision 100ps;

initial begin
    ap_clk = 1'b0;
    forever begin
        #(period_ns / 2) ap_clk = ~ap_clk;
    end
end

// released right after the last reset edge
initial begin
    por_reset = 1'b1;
    repeat (reset_cycles) @(posedge ap_clk);
    por_reset <= 1'b0;
end

endmodule : tb_clock_gen
